// File: compile.f
design/spram_pkg.sv
design/sram_macro_model.sv
design/spram_tiler.sv
design/mem_req_port.sv
design/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// File: design/mem_req_port.sv
`timescale 1ns/100ps
`default_nettype none

module mem_req_port (
    input  logic                          clk,
    input  logic                          rst_n,
    // four phase host side
    input  logic                          req,
    input  spram_pkg::mem_req_t           req_data,  // stable while req is high
    output logic                          ack,
    output spram_pkg::mem_rsp_t           rsp_data,  // valid with ack on reads
    // one cycle strobe to the memory
    output logic                          ce,
    output logic                          we,
    output logic [spram_pkg::ADDR_W-1:0]  addr,
    output logic [spram_pkg::DATA_W-1:0]  din,
    output logic [spram_pkg::DATA_W-1:0]  wmask,     // bit mask with bytes replicated
    input  logic [spram_pkg::DATA_W-1:0]  dout       // one clock after read strobe
);

    typedef enum logic [1:0] {
        st_idle,                            // waiting for req
        st_issue,                           // strobe on the bus
        st_wait_data,                       // write settle or read return
        st_acked                            // ack high until req drops
    } state_t;

    state_t                        state;
    logic                          rd_cap;    // read word already in rsp_data
    logic [spram_pkg::DATA_W-1:0]  bit_mask;  // bmask expanded to bits

    // each byte enable drives 8 mask bits
    always_comb begin
        for (int b = 0; b < spram_pkg::MASK_W; b++) begin
            bit_mask[b*8 +: 8] = {8{req_data.bmask[b]}};
        end
    end

    // handshake FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            ack      <= 1'b0;
            ce       <= 1'b0;
            we       <= 1'b0;
            rd_cap   <= 1'b0;
            rsp_data <= '0;
        end else begin
            ce <= 1'b0;                     // strobe lasts one cycle
            case (state)
                st_idle: begin
                    if (req) begin
                        ce    <= 1'b1;      // issue on the next cycle
                        we    <= req_data.write;
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    rd_cap <= 1'b0;
                    state  <= st_wait_data;
                end
                st_wait_data: begin
                    if (we) begin
                        ack   <= 1'b1;      // write landed on the strobe edge
                        state <= st_acked;
                    end else if (!rd_cap) begin
                        rsp_data.rdata <= dout;  // tiler output settled
                        rd_cap         <= 1'b1;
                    end else begin
                        ack   <= 1'b1;      // data held from here on
                        state <= st_acked;
                    end
                end
                st_acked: begin
                    if (!req) begin
                        ack   <= 1'b0;      // return to zero phase
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload latched with the strobe
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            addr  <= req_data.addr;
            din   <= req_data.wdata;
            wmask <= bit_mask;
        end
    end

    // ack only answers a live request, req seen on the edge that set ack
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
    ) else $error("ack rose while req was low");

    // exactly one memory operation per handshake
    single_strobe: assert property (
        @(posedge clk) disable iff (!rst_n) ce |=> !ce
    ) else $error("ce high on two consecutive cycles");

endmodule

`default_nettype wire

// File: design/mem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,        // four phase request
    input  spram_pkg::mem_req_t  req_data,
    output logic                 ack,
    output spram_pkg::mem_rsp_t  rsp_data
);

    logic                          ce;       // strobe to the tiler
    logic                          we;
    logic [spram_pkg::ADDR_W-1:0]  addr;
    logic [spram_pkg::DATA_W-1:0]  din;
    logic [spram_pkg::DATA_W-1:0]  wmask;
    logic [spram_pkg::DATA_W-1:0]  dout;     // read return

    mem_req_port i_mem_req_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data),
        .ce       (ce),
        .we       (we),
        .addr     (addr),
        .din      (din),
        .wmask    (wmask),
        .dout     (dout)
    );

    spram_tiler #(
        .DW (spram_pkg::DATA_W),             // 96 bits, two slices
        .AW (spram_pkg::ADDR_W)              // 10 bits, four banks
    ) i_spram_tiler (
        .clk   (clk),
        .rst_n (rst_n),
        .ce    (ce),
        .we    (we),
        .wmask (wmask),
        .addr  (addr),
        .din   (din),
        .dout  (dout)
    );

endmodule

`default_nettype wire

// File: design/spram_pkg.sv
`default_nettype none

package spram_pkg;

    // host side word geometry
    localparam int DATA_W = 96;             // host data word
    localparam int ADDR_W = 10;             // word address, 4 banks of 256
    localparam int MASK_W = DATA_W / 8;     // one enable per host byte

    // hard macro geometry, 1rw1r 64x256
    localparam int MACRO_WIDTH      = 64;   // macro data bits
    localparam int MACRO_DEPTH_BITS = 8;    // macro address bits
    localparam int MACRO_MASK_W     = 8;    // one mask bit per macro byte

    // one host access, held stable while req is high
    typedef struct packed {
        logic              write;           // 1 selects write
        logic [ADDR_W-1:0] addr;            // word address
        logic [DATA_W-1:0] wdata;           // write payload
        logic [MASK_W-1:0] bmask;           // 1 writes that byte
    } mem_req_t;

    // read return to the host
    typedef struct packed {
        logic [DATA_W-1:0] rdata;           // last read word
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: design/spram_tiler.sv
`timescale 1ns/100ps
`default_nettype none

module spram_tiler #(
    parameter int DW = 32,                   // memory word width
    parameter int AW = 10                    // word address width
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ce,                // one cycle strobe
    input  logic          we,                // 1 writes, 0 reads
    input  logic [DW-1:0] wmask,             // per bit mask, byte replicated
    input  logic [AW-1:0] addr,
    input  logic [DW-1:0] din,
    output logic [DW-1:0] dout               // valid one clock after read strobe
);

    localparam int MW = spram_pkg::MACRO_WIDTH;        // slice width
    localparam int MD = spram_pkg::MACRO_DEPTH_BITS;   // rows per macro, log2
    localparam int MB = spram_pkg::MACRO_MASK_W;       // mask bits per macro
    localparam int LANE = MW / MB;                     // data bits per mask bit
    localparam int NB = (AW > MD) ? 2 ** (AW - MD) : 1; // address banks
    localparam int NS = (DW + MW - 1) / MW;            // data slices, last may be partial
    localparam int PW = NS * MW;                       // padded word width

    logic [MD-1:0]          mem_addr;   // row inside a macro
    logic [NB-1:0]          bank_sel;   // decoded bank, one hot
    logic [NB-1:0]          sel_q;      // bank of the last read
    logic [PW-1:0]          din_pad;    // write data, top slice tied off
    logic [PW-1:0]          wmask_pad;  // bit mask, top slice tied off
    logic [NS*MB-1:0]       byte_mask;  // one bit per macro byte
    logic [NB-1:0][PW-1:0]  bank_dout;  // raw macro returns per bank
    logic [PW-1:0]          dout_pad;   // or of the selected bank

    // zero extend so inactive bits of the top slice are never written
    assign din_pad   = PW'(din);
    assign wmask_pad = PW'(wmask);

    // bank decode from the upper address bits
    if (NB == 1) begin : g_fits
        assign bank_sel = 1'b1;             // whole space in one row of macros
        assign mem_addr = MD'(addr);
    end else begin : g_banked
        assign mem_addr = addr[MD-1:0];
        for (genvar b = 0; b < NB; b++) begin : g_dec
            assign bank_sel[b] = (addr[AW-1:MD] == (AW - MD)'(b));
        end
    end

    // macro takes a byte mask, lowest bit of each byte stands for the byte
    always_comb begin
        for (int k = 0; k < NS * MB; k++) begin
            byte_mask[k] = wmask_pad[k*LANE];
        end
    end

    // macro array, banks by slices
    for (genvar b = 0; b < NB; b++) begin : g_bank
        logic wr_en;                        // write strobe for this bank
        logic rd_en;                        // read strobe for this bank

        assign wr_en = ce && we && bank_sel[b];
        assign rd_en = ce && !we && bank_sel[b];

        for (genvar s = 0; s < NS; s++) begin : g_slice
            sram_macro_model i_sram_macro_model (
                .clk0   (clk),
                .csb0   (!wr_en),                          // selects on write only
                .web0   (!wr_en),
                .wmask0 (byte_mask[s*MB +: MB]),
                .addr0  (mem_addr),
                .din0   (din_pad[s*MW +: MW]),
                .clk1   (clk),
                .csb1   (!rd_en),                          // read port for loads
                .addr1  (mem_addr),
                .dout1  (bank_dout[b][s*MW +: MW])
            );
        end
    end

    // remember which bank answers the read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (ce && !we) begin
            sel_q <= bank_sel;              // held so dout stays put between reads
        end
    end

    // gate each bank return and or them together
    always_comb begin
        dout_pad = '0;
        for (int b = 0; b < NB; b++) begin
            if (sel_q[b]) begin
                dout_pad = dout_pad | bank_dout[b];
            end
        end
    end

    assign dout = dout_pad[DW-1:0];         // drop padding of the top slice

    // decode and registered select agree on exactly one bank per read
    sel_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) (ce && !we) |=> $onehot(sel_q)
    ) else $error("read select not one hot: %b", sel_q);

    // macro return reaches dout clean on the following cycle
    dout_known: assert property (
        @(posedge clk) disable iff (!rst_n) (ce && !we) |=> !$isunknown(dout)
    ) else $error("read data has unknown bits");

endmodule

`default_nettype wire

// File: design/sram_macro_model.sv
`timescale 1ns/100ps
`default_nettype none

module sram_macro_model (
    // port 0, write only here
    input  logic                                    clk0,
    input  logic                                    csb0,    // chip select, active low
    input  logic                                    web0,    // write enable, active low
    input  logic [spram_pkg::MACRO_MASK_W-1:0]      wmask0,  // byte enables
    input  logic [spram_pkg::MACRO_DEPTH_BITS-1:0]  addr0,
    input  logic [spram_pkg::MACRO_WIDTH-1:0]       din0,
    // port 1, read only
    input  logic                                    clk1,
    input  logic                                    csb1,    // chip select, active low
    input  logic [spram_pkg::MACRO_DEPTH_BITS-1:0]  addr1,
    output logic [spram_pkg::MACRO_WIDTH-1:0]       dout1    // registered read word
);

    localparam int WORDS = 2 ** spram_pkg::MACRO_DEPTH_BITS;              // 256 rows
    localparam int LANE  = spram_pkg::MACRO_WIDTH / spram_pkg::MACRO_MASK_W; // bits per mask bit

    logic [spram_pkg::MACRO_WIDTH-1:0] mem [WORDS];  // bit cell array

    // array powers up cleared in this model
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // port 0 byte masked write
    always_ff @(posedge clk0) begin
        if (!csb0 && !web0) begin
            for (int k = 0; k < spram_pkg::MACRO_MASK_W; k++) begin
                if (wmask0[k]) begin
                    mem[addr0][k*LANE +: LANE] <= din0[k*LANE +: LANE];  // only enabled lanes
                end
            end
        end
    end

    // port 1 read, output holds when deselected
    always_ff @(posedge clk1) begin
        if (!csb1) begin
            dout1 <= mem[addr1];
        end
    end

    // simultaneous write and read of one row gives undefined data on the real cell
    no_rw_collision: assert property (
        @(posedge clk0) (!csb0 && !web0 && !csb1) |-> (addr0 != addr1)
    ) else $error("macro write and read to row %0d on the same edge", addr0);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the memory subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_mem_subsys \
    -o sim_mem_subsys

out=$(./obj_dir/sim_mem_subsys)
echo "$out"
echo "$out" | grep -q "^NO ERRORS$"

// File: tests/tb_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;

    localparam int DW      = spram_pkg::DATA_W;
    localparam int AW      = spram_pkg::ADDR_W;
    localparam int MK      = spram_pkg::MASK_W;
    localparam int DEPTH   = 2 ** AW;                // 1024 words
    localparam int TIMEOUT = 50;                     // cycles per wait loop

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 req;
    spram_pkg::mem_req_t  req_data;
    logic                 ack;
    spram_pkg::mem_rsp_t  rsp_data;

    logic [DW-1:0]        shadow [DEPTH];            // reference memory, zero at start
    logic [DW-1:0]        exp_q [$];                 // expected word per request
    bit                   rd_q [$];                  // 1 when that request is a read
    logic                 ack_q = 1'b0;              // ack seen at the previous edge
    logic [DW-1:0]        exp_word;
    bit                   exp_rd;
    bit                   hung = 1'b0;               // a wait loop ran out
    int                   errors = 0;
    int                   checks = 0;

    mem_subsys_top i_mem_subsys_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

    always #5 clk = ~clk;                            // 10 ns period

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // byte mask rule, returns the word a read would see afterwards
    function automatic logic [DW-1:0] ref_access(input spram_pkg::mem_req_t r);
        if (r.write) begin
            for (int b = 0; b < MK; b++) begin
                if (r.bmask[b]) begin
                    shadow[r.addr][b*8 +: 8] = r.wdata[b*8 +: 8];
                end
            end
        end
        return shadow[r.addr];
    endfunction

    function automatic spram_pkg::mem_req_t make_req(input logic wr, input logic [AW-1:0] a,
                                                     input logic [DW-1:0] d,
                                                     input logic [MK-1:0] m);
        spram_pkg::mem_req_t r;
        r.write = wr;
        r.addr  = a;
        r.wdata = d;
        r.bmask = m;
        return r;
    endfunction

    function automatic logic [DW-1:0] rand_word();
        return {$urandom(), $urandom(), $urandom()};
    endfunction

    // one four phase handshake, entered and left 1 ns after an edge
    task automatic do_access(input spram_pkg::mem_req_t r, input int hold);
        logic [DW-1:0] held;
        int n;
        if (hung) begin
            return;                                  // DUT already stuck
        end
        exp_q.push_back(ref_access(r));
        rd_q.push_back(!r.write);
        req_data = r;
        req      = 1'b1;
        n = 0;
        while (!ack && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ack) begin
            $display("timeout: ack never rose for request to address %0d", r.addr);
            errors++;
            hung = 1'b1;
            return;
        end
        check_value("ack rise latency", DW'(n - 1), DW'(r.write ? 2 : 3));  // from sample edge
        held = rsp_data.rdata;
        repeat (hold) begin                          // host stalls the return phase
            @(posedge clk);
            #1;
            check_value("ack", DW'(ack), DW'(1));
            check_value("rsp_data.rdata", rsp_data.rdata, held);
        end
        req = 1'b0;
        n = 0;
        while (ack && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ack) begin
            $display("timeout: ack stayed high after req dropped, address %0d", r.addr);
            errors++;
            hung = 1'b1;
            return;
        end
        check_value("ack fall latency", DW'(n), DW'(1));
    endtask

    // read data checked on the first edge that sees ack high
    always @(posedge clk) begin
        if (rst_n && ack && !ack_q && exp_q.size() > 0) begin
            exp_word = exp_q.pop_front();
            exp_rd   = rd_q.pop_front();
            if (exp_rd) begin
                check_value("rsp_data.rdata", rsp_data.rdata, exp_word);
            end
        end
        ack_q = ack;
    end

    initial begin
        logic [AW-1:0] edge_addr [8];
        logic [MK-1:0] part_mask [4];
        void'($urandom(38278));
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = '0;
        end
        rst_n    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        repeat (4) @(posedge clk);                   // reset for 4 cycles
        #1;
        rst_n = 1'b1;

        // idle outputs after reset
        repeat (2) begin
            @(posedge clk);
            #1;
            check_value("ack", DW'(ack), '0);
            check_value("rsp_data.rdata", rsp_data.rdata, '0);
        end

        // full word per bank, both ends of each
        edge_addr = '{10'd0, 10'd255, 10'd256, 10'd511, 10'd512, 10'd767, 10'd768, 10'd1023};
        foreach (edge_addr[i]) begin
            do_access(make_req(1'b1, edge_addr[i], rand_word(), '1), 0);
            do_access(make_req(1'b0, edge_addr[i], '0, '0), 0);
        end

        // partial masks merge into an old word, upper slice included
        part_mask = '{12'h005, 12'hA00, 12'h000, 12'h8F1};
        do_access(make_req(1'b1, 10'd300, rand_word(), '1), 0);
        foreach (part_mask[i]) begin
            do_access(make_req(1'b1, 10'd300, rand_word(), part_mask[i]), 0);
            do_access(make_req(1'b0, 10'd300, '0, '0), 0);
        end
        do_access(make_req(1'b1, 10'd900, rand_word(), 12'hC00), 0);  // never written before
        do_access(make_req(1'b0, 10'd900, '0, '0), 0);

        // host holds req well past ack
        do_access(make_req(1'b1, 10'd42, rand_word(), '1), 5);
        do_access(make_req(1'b0, 10'd42, '0, '0), 5);
        do_access(make_req(1'b0, 10'd600, '0, '0), 3);

        // random traffic
        for (int i = 0; i < 300; i++) begin
            do_access(make_req(1'($urandom() % 2), AW'($urandom() % DEPTH), rand_word(),
                               MK'($urandom())), int'($urandom() % 3));
        end

        if (!hung && exp_q.size() != 0) begin
            $display("read results missing for %0d requests", exp_q.size());
            errors++;
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
